// File: hdl/huff_pkg.sv
package huff_pkg;

  // one 7-bit character chunk from the host
  typedef logic [6:0] chunk_t;

  // byte symbol, also the histogram index
  typedef logic [7:0] sym_t;

  // histogram count and SRAM data word
  typedef logic [31:0] count_t;

  // wishbone byte address
  typedef logic [31:0] wb_addr_t;

  // controller phases
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CLEAR,
    PH_COUNT,
    PH_SCAN,
    PH_DONE
  } phase_t;

  // chunk buffer depth, equal to the host credits after reset
  localparam int CHUNK_CREDITS = 2;
  localparam int NUM_SYMS = 256;

  // SRAM byte address of histogram entry 0
  localparam wb_addr_t HIST_BASE = 32'h3000_0000;

  // word address of one histogram entry
  function automatic wb_addr_t hist_addr(input sym_t sym);
    return HIST_BASE + {22'd0, sym, 2'b00};
  endfunction

endpackage

// File: hdl/chunk_packer.sv
`timescale 1ns/1ps
module chunk_packer (
  input  logic             hwclk,
  input  logic             reset,
  input  logic             chunk_valid_i,
  input  logic             eof_i,
  input  huff_pkg::chunk_t chunk_i,
  input  logic             byte_ready_i,
  output logic             credit_o,
  output logic             byte_valid_o,
  output logic             eof_seen_o,
  output huff_pkg::sym_t   byte_o
);

  huff_pkg::chunk_t buf_chunk [huff_pkg::CHUNK_CREDITS];
  logic             buf_eof [huff_pkg::CHUNK_CREDITS];
  logic [$clog2(huff_pkg::CHUNK_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(huff_pkg::CHUNK_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(huff_pkg::CHUNK_CREDITS+1)-1:0] used;

  // bit accumulator, at most 7 leftover plus one chunk
  logic [13:0] acc;
  logic [3:0]  fill;
  logic        eof_popped;

  logic        take;
  logic        pop;
  logic [13:0] merged;
  logic [3:0]  merged_fill;

  always_comb begin
    take = byte_valid_o & byte_ready_i;
    pop = (used != '0) && (fill < 4'd8) && (!byte_valid_o || take);
    // new chunk sits above the bits already held
    merged = acc | (14'(buf_chunk[rd_ptr]) << fill);
    merged_fill = fill + 4'd7;
  end

  // no whole byte left once the eof chunk is out
  assign eof_seen_o = eof_popped & ~byte_valid_o;

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used <= '0;
      acc <= '0;
      fill <= '0;
      byte_valid_o <= 1'b0;
      eof_popped <= 1'b0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;
      if (chunk_valid_i) begin
        wr_ptr <= wr_ptr + 1'b1;
        // first chunk of the next message
        eof_popped <= 1'b0;
      end
      case ({chunk_valid_i, pop})
        2'b10: used <= used + 1'b1;
        2'b01: used <= used - 1'b1;
        default: ;
      endcase
      if (take) begin
        byte_valid_o <= 1'b0;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        if (merged_fill >= 4'd8) begin
          byte_valid_o <= 1'b1;
        end
        if (buf_eof[rd_ptr]) begin
          // leftover bits of the message are dropped
          acc <= '0;
          fill <= '0;
          eof_popped <= 1'b1;
        end else if (merged_fill >= 4'd8) begin
          acc <= merged >> 8;
          fill <= merged_fill - 4'd8;
        end else begin
          acc <= merged;
          fill <= merged_fill;
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (chunk_valid_i) begin
      buf_chunk[wr_ptr] <= chunk_i;
      buf_eof[wr_ptr] <= eof_i;
    end
    if (pop && merged_fill >= 4'd8) begin
      byte_o <= merged[7:0];
    end
  end

endmodule

// File: hdl/wb_manager.sv
`timescale 1ns/1ps
module wb_manager (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               req_i,
  input  logic               we_i,
  input  huff_pkg::wb_addr_t addr_i,
  input  huff_pkg::count_t   wdata_i,
  output logic               busy_o,
  output huff_pkg::count_t   rdata_o,
  output logic               wbs_cyc_o,
  output logic               wbs_stb_o,
  output logic               wbs_we_o,
  output logic [3:0]         wbs_sel_o,
  output huff_pkg::wb_addr_t wbs_adr_o,
  output huff_pkg::count_t   wbs_dat_o,
  input  logic               wbs_ack_i,
  input  huff_pkg::count_t   wbs_dat_i
);

  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_t;

  wb_state_t state;

  assign busy_o = (state == WB_BUSY);
  // word accesses only
  assign wbs_sel_o = 4'hf;
  assign wbs_stb_o = wbs_cyc_o;

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      state <= WB_IDLE;
      wbs_cyc_o <= 1'b0;
      wbs_we_o <= 1'b0;
    end else begin
      case (state)
        WB_IDLE: begin
          if (req_i) begin
            state <= WB_BUSY;
            wbs_cyc_o <= 1'b1;
            wbs_we_o <= we_i;
          end
        end
        WB_BUSY: begin
          // bus released the cycle after ack
          if (wbs_ack_i) begin
            state <= WB_IDLE;
            wbs_cyc_o <= 1'b0;
            wbs_we_o <= 1'b0;
          end
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (state == WB_IDLE && req_i) begin
      wbs_adr_o <= addr_i;
      wbs_dat_o <= wdata_i;
    end
    if (state == WB_BUSY && wbs_ack_i && !wbs_we_o) begin
      rdata_o <= wbs_dat_i;
    end
  end

endmodule

// File: hdl/hist_builder.sv
`timescale 1ns/1ps
module hist_builder (
  input  logic               hwclk,
  input  logic               reset,
  input  huff_pkg::phase_t   phase_i,
  input  logic               byte_valid_i,
  input  huff_pkg::sym_t     byte_i,
  input  logic               busy_i,
  input  huff_pkg::count_t   rdata_i,
  output logic               req_o,
  output logic               we_o,
  output logic               byte_ready_o,
  output logic               clear_done_o,
  output logic               count_done_o,
  output huff_pkg::wb_addr_t addr_o,
  output huff_pkg::count_t   wdata_o,
  output huff_pkg::count_t   total_o
);

  typedef enum logic [1:0] {
    HB_IDLE,
    HB_CLR_WAIT,
    HB_RD_WAIT,
    HB_WR_WAIT
  } hb_state_t;

  hb_state_t      state;
  huff_pkg::sym_t clr_idx;
  huff_pkg::sym_t sym_q;

  always_comb begin
    req_o = 1'b0;
    we_o = 1'b0;
    byte_ready_o = 1'b0;
    wdata_o = '0;
    addr_o = huff_pkg::hist_addr(sym_q);
    case (state)
      HB_IDLE: begin
        if (phase_i == huff_pkg::PH_CLEAR && !clear_done_o) begin
          req_o = 1'b1;
          we_o = 1'b1;
          addr_o = huff_pkg::hist_addr(clr_idx);
        end else if (phase_i == huff_pkg::PH_COUNT) begin
          // read the entry of the incoming byte
          byte_ready_o = 1'b1;
          req_o = byte_valid_i;
          addr_o = huff_pkg::hist_addr(byte_i);
        end
      end
      HB_RD_WAIT: begin
        if (!busy_i) begin
          req_o = 1'b1;
          we_o = 1'b1;
          wdata_o = rdata_i + 1'b1;
        end
      end
      default: ;
    endcase
  end

  // packer eof is ANDed in at the top level
  assign count_done_o = (phase_i == huff_pkg::PH_COUNT) && (state == HB_IDLE);

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      state <= HB_IDLE;
      clr_idx <= '0;
      clear_done_o <= 1'b0;
      total_o <= '0;
    end else begin
      if (phase_i != huff_pkg::PH_CLEAR) begin
        clear_done_o <= 1'b0;
      end else begin
        total_o <= '0;
      end
      case (state)
        HB_IDLE: begin
          if (req_o) begin
            state <= we_o ? HB_CLR_WAIT : HB_RD_WAIT;
          end
        end
        HB_CLR_WAIT: begin
          if (!busy_i) begin
            state <= HB_IDLE;
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == huff_pkg::sym_t'(huff_pkg::NUM_SYMS - 1)) begin
              clear_done_o <= 1'b1;
            end
          end
        end
        HB_RD_WAIT: begin
          if (!busy_i) begin
            state <= HB_WR_WAIT;
            total_o <= total_o + 1'b1;
          end
        end
        HB_WR_WAIT: begin
          if (!busy_i) begin
            state <= HB_IDLE;
          end
        end
        default: state <= HB_IDLE;
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (byte_ready_o && byte_valid_i) begin
      sym_q <= byte_i;
    end
  end

endmodule

// File: hdl/least_finder.sv
`timescale 1ns/1ps
module least_finder (
  input  logic               hwclk,
  input  logic               reset,
  input  huff_pkg::phase_t   phase_i,
  input  logic               busy_i,
  input  huff_pkg::count_t   rdata_i,
  output logic               req_o,
  output logic               scan_done_o,
  output huff_pkg::wb_addr_t addr_o,
  output huff_pkg::sym_t     least1_sym_o,
  output huff_pkg::sym_t     least2_sym_o,
  output huff_pkg::count_t   least1_cnt_o,
  output huff_pkg::count_t   least2_cnt_o
);

  typedef enum logic {
    LF_IDLE,
    LF_WAIT
  } lf_state_t;

  lf_state_t      state;
  huff_pkg::sym_t idx;

  assign req_o = (state == LF_IDLE) && (phase_i == huff_pkg::PH_SCAN) && !scan_done_o;
  assign addr_o = huff_pkg::hist_addr(idx);

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      state <= LF_IDLE;
      idx <= '0;
      scan_done_o <= 1'b0;
      least1_sym_o <= '0;
      least1_cnt_o <= '0;
      least2_sym_o <= '0;
      least2_cnt_o <= '0;
    end else begin
      if (phase_i != huff_pkg::PH_SCAN) begin
        scan_done_o <= 1'b0;
      end
      // a zero count marks an empty slot
      if (phase_i == huff_pkg::PH_CLEAR) begin
        least1_sym_o <= '0;
        least1_cnt_o <= '0;
        least2_sym_o <= '0;
        least2_cnt_o <= '0;
      end
      case (state)
        LF_IDLE: begin
          if (req_o) begin
            state <= LF_WAIT;
          end
        end
        LF_WAIT: begin
          if (!busy_i) begin
            state <= LF_IDLE;
            idx <= idx + 1'b1;
            if (idx == huff_pkg::sym_t'(huff_pkg::NUM_SYMS - 1)) begin
              scan_done_o <= 1'b1;
            end
            // strict compare keeps the lower index on ties
            if (rdata_i != '0) begin
              if (least1_cnt_o == '0 || rdata_i < least1_cnt_o) begin
                least2_sym_o <= least1_sym_o;
                least2_cnt_o <= least1_cnt_o;
                least1_sym_o <= idx;
                least1_cnt_o <= rdata_i;
              end else if (least2_cnt_o == '0 || rdata_i < least2_cnt_o) begin
                least2_sym_o <= idx;
                least2_cnt_o <= rdata_i;
              end
            end
          end
        end
        default: state <= LF_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/huff_controller.sv
`timescale 1ns/1ps
module huff_controller (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               start_i,
  input  logic               eof_seen_i,
  input  logic               clear_done_i,
  input  logic               count_done_i,
  input  logic               scan_done_i,
  output huff_pkg::phase_t   phase_o,
  input  logic               hb_req_i,
  input  logic               hb_we_i,
  input  huff_pkg::wb_addr_t hb_addr_i,
  input  huff_pkg::count_t   hb_wdata_i,
  input  logic               lf_req_i,
  input  huff_pkg::wb_addr_t lf_addr_i,
  output logic               req_o,
  output logic               we_o,
  output huff_pkg::wb_addr_t addr_o,
  output huff_pkg::count_t   wdata_o
);

  always_ff @(posedge hwclk or posedge reset) begin
    if (reset) begin
      phase_o <= huff_pkg::PH_IDLE;
    end else begin
      case (phase_o)
        huff_pkg::PH_IDLE, huff_pkg::PH_DONE: begin
          if (start_i) begin
            phase_o <= huff_pkg::PH_CLEAR;
          end
        end
        huff_pkg::PH_CLEAR: begin
          if (clear_done_i) begin
            phase_o <= huff_pkg::PH_COUNT;
          end
        end
        huff_pkg::PH_COUNT: begin
          // last byte counted and no update in flight
          if (eof_seen_i && count_done_i) begin
            phase_o <= huff_pkg::PH_SCAN;
          end
        end
        huff_pkg::PH_SCAN: begin
          if (scan_done_i) begin
            phase_o <= huff_pkg::PH_DONE;
          end
        end
        default: phase_o <= huff_pkg::PH_IDLE;
      endcase
    end
  end

  // manager request mux
  always_comb begin
    req_o = 1'b0;
    we_o = 1'b0;
    addr_o = hb_addr_i;
    wdata_o = hb_wdata_i;
    case (phase_o)
      huff_pkg::PH_CLEAR, huff_pkg::PH_COUNT: begin
        req_o = hb_req_i;
        we_o = hb_we_i;
      end
      huff_pkg::PH_SCAN: begin
        req_o = lf_req_i;
        addr_o = lf_addr_i;
        wdata_o = '0;
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/huff_front_top.sv
`timescale 1ns/1ps
module huff_front_top (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               start_i,
  input  logic               chunk_valid_i,
  input  huff_pkg::chunk_t   chunk_i,
  input  logic               eof_i,
  output logic               credit_o,
  output logic               done_o,
  output huff_pkg::count_t   total_o,
  output huff_pkg::sym_t     least1_sym_o,
  output huff_pkg::count_t   least1_cnt_o,
  output huff_pkg::sym_t     least2_sym_o,
  output huff_pkg::count_t   least2_cnt_o,
  output logic               wbs_cyc_o,
  output logic               wbs_stb_o,
  output logic               wbs_we_o,
  output logic [3:0]         wbs_sel_o,
  output huff_pkg::wb_addr_t wbs_adr_o,
  output huff_pkg::count_t   wbs_dat_o,
  input  logic               wbs_ack_i,
  input  huff_pkg::count_t   wbs_dat_i
);

  huff_pkg::phase_t   phase;
  logic               eof_seen;
  logic               clear_done;
  logic               hb_count_done;
  logic               count_done;
  logic               scan_done;
  logic               byte_valid;
  logic               byte_ready;
  huff_pkg::sym_t     byte_val;
  logic               hb_req;
  logic               hb_we;
  huff_pkg::wb_addr_t hb_addr;
  huff_pkg::count_t   hb_wdata;
  logic               lf_req;
  huff_pkg::wb_addr_t lf_addr;
  logic               mgr_req;
  logic               mgr_we;
  huff_pkg::wb_addr_t mgr_addr;
  huff_pkg::count_t   mgr_wdata;
  logic               mgr_busy;
  huff_pkg::count_t   mgr_rdata;

  assign done_o = (phase == huff_pkg::PH_DONE);
  assign count_done = eof_seen & hb_count_done;

  huff_controller u_huff_controller (
    .hwclk        (hwclk),
    .reset        (reset),
    .start_i      (start_i),
    .eof_seen_i   (eof_seen),
    .clear_done_i (clear_done),
    .count_done_i (count_done),
    .scan_done_i  (scan_done),
    .phase_o      (phase),
    .hb_req_i     (hb_req),
    .hb_we_i      (hb_we),
    .hb_addr_i    (hb_addr),
    .hb_wdata_i   (hb_wdata),
    .lf_req_i     (lf_req),
    .lf_addr_i    (lf_addr),
    .req_o        (mgr_req),
    .we_o         (mgr_we),
    .addr_o       (mgr_addr),
    .wdata_o      (mgr_wdata)
  );

  chunk_packer u_chunk_packer (
    .hwclk         (hwclk),
    .reset         (reset),
    .chunk_valid_i (chunk_valid_i),
    .eof_i         (eof_i),
    .chunk_i       (chunk_i),
    .byte_ready_i  (byte_ready),
    .credit_o      (credit_o),
    .byte_valid_o  (byte_valid),
    .eof_seen_o    (eof_seen),
    .byte_o        (byte_val)
  );

  hist_builder u_hist_builder (
    .hwclk        (hwclk),
    .reset        (reset),
    .phase_i      (phase),
    .byte_valid_i (byte_valid),
    .byte_i       (byte_val),
    .busy_i       (mgr_busy),
    .rdata_i      (mgr_rdata),
    .req_o        (hb_req),
    .we_o         (hb_we),
    .byte_ready_o (byte_ready),
    .clear_done_o (clear_done),
    .count_done_o (hb_count_done),
    .addr_o       (hb_addr),
    .wdata_o      (hb_wdata),
    .total_o      (total_o)
  );

  least_finder u_least_finder (
    .hwclk        (hwclk),
    .reset        (reset),
    .phase_i      (phase),
    .busy_i       (mgr_busy),
    .rdata_i      (mgr_rdata),
    .req_o        (lf_req),
    .scan_done_o  (scan_done),
    .addr_o       (lf_addr),
    .least1_sym_o (least1_sym_o),
    .least2_sym_o (least2_sym_o),
    .least1_cnt_o (least1_cnt_o),
    .least2_cnt_o (least2_cnt_o)
  );

  wb_manager u_wb_manager (
    .hwclk     (hwclk),
    .reset     (reset),
    .req_i     (mgr_req),
    .we_i      (mgr_we),
    .addr_i    (mgr_addr),
    .wdata_i   (mgr_wdata),
    .busy_o    (mgr_busy),
    .rdata_o   (mgr_rdata),
    .wbs_cyc_o (wbs_cyc_o),
    .wbs_stb_o (wbs_stb_o),
    .wbs_we_o  (wbs_we_o),
    .wbs_sel_o (wbs_sel_o),
    .wbs_adr_o (wbs_adr_o),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_i (wbs_ack_i),
    .wbs_dat_i (wbs_dat_i)
  );

endmodule

// File: dv/huff_checker.sv
`timescale 1ns/1ps
module huff_checker (
  input  logic               hwclk,
  input  logic               reset,
  input  int                 test_id_i,
  input  logic               start_i,
  input  logic               chunk_valid_i,
  input  huff_pkg::chunk_t   chunk_i,
  input  logic               eof_i,
  input  logic               credit_i,
  input  logic               done_i,
  input  huff_pkg::count_t   total_i,
  input  huff_pkg::sym_t     least1_sym_i,
  input  huff_pkg::count_t   least1_cnt_i,
  input  huff_pkg::sym_t     least2_sym_i,
  input  huff_pkg::count_t   least2_cnt_i,
  input  logic               wbs_cyc_i,
  input  logic               wbs_stb_i,
  input  logic               wbs_we_i,
  input  logic [3:0]         wbs_sel_i,
  input  huff_pkg::wb_addr_t wbs_adr_i,
  input  logic               wbs_ack_i,
  output int                 tests_run_o,
  output int                 tests_failed_o,
  output int                 errors_o
);

  huff_pkg::count_t hist_m [huff_pkg::NUM_SYMS];
  huff_pkg::count_t total_m = '0;
  huff_pkg::sym_t   byte_m;
  logic [13:0]      acc_m = '0;
  int               fill_m = 0;
  // chunks sent and not yet credited back
  int               outstanding = 0;
  int               test_errs = 0;
  int               runs = 0;
  int               fails = 0;
  int               err_total = 0;
  logic             done_q = 1'b0;
  logic             ack_q = 1'b0;
  huff_pkg::sym_t   exp1_sym;
  huff_pkg::count_t exp1_cnt;
  huff_pkg::sym_t   exp2_sym;
  huff_pkg::count_t exp2_cnt;

  assign tests_run_o = runs;
  assign tests_failed_o = fails;
  assign errors_o = err_total;

  function automatic string test_name(input int id);
    case (id)
      0: return "fixed_short";
      1: return "random_200";
      2: return "single_symbol";
      3: return "restart";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_error(input string what);
    $display("%s (test %s)", what, test_name(test_id_i));
    test_errs++;
    err_total++;
  endtask

  task automatic check_value(input string field, input huff_pkg::count_t expected,
                             input huff_pkg::count_t actual);
    if (expected !== actual) begin
      $display("error %s %s: expected %0d, actual %0d", test_name(test_id_i), field,
               expected, actual);
      test_errs++;
      err_total++;
    end
  endtask

  // smallest nonzero count first and then the smallest of the rest
  task automatic expected_least(output huff_pkg::sym_t s1, output huff_pkg::count_t c1,
                                output huff_pkg::sym_t s2, output huff_pkg::count_t c2);
    s1 = '0;
    c1 = '0;
    s2 = '0;
    c2 = '0;
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (hist_m[i] != '0 && (c1 == '0 || hist_m[i] < c1)) begin
        s1 = huff_pkg::sym_t'(i);
        c1 = hist_m[i];
      end
    end
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (i != int'(s1) && hist_m[i] != '0 && (c2 == '0 || hist_m[i] < c2)) begin
        s2 = huff_pkg::sym_t'(i);
        c2 = hist_m[i];
      end
    end
  endtask

  always @(posedge hwclk) begin
    if (reset) begin
      if (credit_i || done_i || wbs_cyc_i || wbs_stb_i || wbs_we_i) begin
        report_error("DUT outputs are not low while reset is held");
      end
      outstanding = 0;
      acc_m = '0;
      fill_m = 0;
      done_q = 1'b0;
      ack_q = 1'b0;
    end else begin
      if (start_i) begin
        for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
          hist_m[i] = '0;
        end
        total_m = '0;
      end
      // new chunk lands above the held bits
      if (chunk_valid_i) begin
        acc_m = acc_m | (14'(chunk_i) << fill_m);
        fill_m = fill_m + 7;
        if (fill_m >= 8) begin
          byte_m = acc_m[7:0];
          hist_m[byte_m] = hist_m[byte_m] + 32'd1;
          total_m = total_m + 32'd1;
          acc_m = acc_m >> 8;
          fill_m = fill_m - 8;
        end
        if (eof_i) begin
          acc_m = '0;
          fill_m = 0;
        end
      end
      if (chunk_valid_i) begin
        outstanding++;
      end
      if (credit_i) begin
        outstanding--;
      end
      if (outstanding > huff_pkg::CHUNK_CREDITS) begin
        report_error("more chunks outstanding than the host has credits");
      end
      if (outstanding < 0) begin
        report_error("credit returned with no chunk outstanding");
      end
      if (wbs_stb_i != wbs_cyc_i) begin
        report_error("wishbone strobe does not follow the cycle signal");
      end
      if (ack_q && wbs_cyc_i) begin
        report_error("wishbone cycle still open in the cycle after ack");
      end
      ack_q = wbs_ack_i;
      if (wbs_cyc_i && wbs_stb_i) begin
        if (wbs_sel_i != 4'hf) begin
          report_error("wishbone select does not cover all four byte lanes");
        end
        if (wbs_adr_i[31:10] != huff_pkg::HIST_BASE[31:10] || wbs_adr_i[1:0] != 2'b00) begin
          report_error("wishbone address falls outside the histogram");
        end
      end
      if (done_i && !done_q) begin
        expected_least(exp1_sym, exp1_cnt, exp2_sym, exp2_cnt);
        check_value("total", total_m, total_i);
        check_value("least1_sym", huff_pkg::count_t'(exp1_sym),
                    huff_pkg::count_t'(least1_sym_i));
        check_value("least1_cnt", exp1_cnt, least1_cnt_i);
        check_value("least2_sym", huff_pkg::count_t'(exp2_sym),
                    huff_pkg::count_t'(least2_sym_i));
        check_value("least2_cnt", exp2_cnt, least2_cnt_i);
        if (outstanding != 0) begin
          report_error("credits still outstanding when done rose");
        end
        if (test_errs == 0) begin
          $display("test %s: pass", test_name(test_id_i));
        end else begin
          $display("test %s: fail with %0d errors", test_name(test_id_i), test_errs);
          fails++;
        end
        runs++;
        test_errs = 0;
      end
      done_q = done_i;
    end
  end

endmodule

// File: dv/tb_huff_front.sv
`timescale 1ns/1ps
module tb_huff_front;

  localparam int NUM_TESTS = 4;
  localparam logic [31:0] SEED = 32'h4c04_9f89;
  // chunks per test for the fixed, random, single symbol and restart cases
  localparam int MSG_LEN [NUM_TESTS] = '{4, 200, 16, 40};

  logic               hwclk;
  logic               reset;
  logic               start_i;
  logic               chunk_valid_i;
  huff_pkg::chunk_t   chunk_i;
  logic               eof_i;
  logic               credit_o;
  logic               done_o;
  huff_pkg::count_t   total_o;
  huff_pkg::sym_t     least1_sym_o;
  huff_pkg::count_t   least1_cnt_o;
  huff_pkg::sym_t     least2_sym_o;
  huff_pkg::count_t   least2_cnt_o;
  logic               wbs_cyc_o;
  logic               wbs_stb_o;
  logic               wbs_we_o;
  logic [3:0]         wbs_sel_o;
  huff_pkg::wb_addr_t wbs_adr_o;
  huff_pkg::count_t   wbs_dat_o;
  logic               wbs_ack_i;
  huff_pkg::count_t   wbs_dat_i;

  huff_pkg::chunk_t   msg [$];
  huff_pkg::count_t   mem [huff_pkg::NUM_SYMS];
  logic [31:0]        host_lfsr = SEED;
  logic [31:0]        ack_lfsr = SEED;
  logic [31:0]        ack_val;
  logic               ack_armed = 1'b0;
  int                 ack_wait;
  huff_pkg::sym_t     sram_idx;
  int                 credits;
  int                 test_id;
  int                 cycles = 0;
  int                 limit;
  int                 tests_run;
  int                 tests_failed;
  int                 errors;

  initial begin
    hwclk = 1'b0;
    forever #2 hwclk = ~hwclk;
  end

  huff_front_top u_huff_front_top (
    .hwclk         (hwclk),
    .reset         (reset),
    .start_i       (start_i),
    .chunk_valid_i (chunk_valid_i),
    .chunk_i       (chunk_i),
    .eof_i         (eof_i),
    .credit_o      (credit_o),
    .done_o        (done_o),
    .total_o       (total_o),
    .least1_sym_o  (least1_sym_o),
    .least1_cnt_o  (least1_cnt_o),
    .least2_sym_o  (least2_sym_o),
    .least2_cnt_o  (least2_cnt_o),
    .wbs_cyc_o     (wbs_cyc_o),
    .wbs_stb_o     (wbs_stb_o),
    .wbs_we_o      (wbs_we_o),
    .wbs_sel_o     (wbs_sel_o),
    .wbs_adr_o     (wbs_adr_o),
    .wbs_dat_o     (wbs_dat_o),
    .wbs_ack_i     (wbs_ack_i),
    .wbs_dat_i     (wbs_dat_i)
  );

  huff_checker u_huff_checker (
    .hwclk          (hwclk),
    .reset          (reset),
    .test_id_i      (test_id),
    .start_i        (start_i),
    .chunk_valid_i  (chunk_valid_i),
    .chunk_i        (chunk_i),
    .eof_i          (eof_i),
    .credit_i       (credit_o),
    .done_i         (done_o),
    .total_i        (total_o),
    .least1_sym_i   (least1_sym_o),
    .least1_cnt_i   (least1_cnt_o),
    .least2_sym_i   (least2_sym_o),
    .least2_cnt_i   (least2_cnt_o),
    .wbs_cyc_i      (wbs_cyc_o),
    .wbs_stb_i      (wbs_stb_o),
    .wbs_we_i       (wbs_we_o),
    .wbs_sel_i      (wbs_sel_o),
    .wbs_adr_i      (wbs_adr_o),
    .wbs_ack_i      (wbs_ack_i),
    .tests_run_o    (tests_run),
    .tests_failed_o (tests_failed),
    .errors_o       (errors)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      val = {val[30:0], state[0]};
    end
  endtask

  // 16 cycles per byte plus 512 bus accesses of 5 cycles per test
  function automatic int cycle_limit();
    int bytes;
    bytes = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      bytes += MSG_LEN[t] * 7 / 8;
    end
    return bytes * 16 + 512 * 5 * NUM_TESTS + 1000;
  endfunction

  task automatic next_cycle();
    @(posedge hwclk);
    #1;
    if (credit_o) begin
      credits++;
    end
  endtask

  task automatic build_message(input int id);
    logic [31:0] val;
    msg.delete();
    for (int i = 0; i < MSG_LEN[id]; i++) begin
      case (id)
        0: msg.push_back(huff_pkg::chunk_t'(7'h41 + i));
        // all ones packs to 8'hff only
        2: msg.push_back(7'h7f);
        default: begin
          take_bits(host_lfsr, 7, val);
          msg.push_back(huff_pkg::chunk_t'(val));
        end
      endcase
    end
  endtask

  task automatic run_test(input int id);
    int          sent;
    int          gap;
    int          runs_before;
    logic [31:0] val;
    sent = 0;
    gap = 0;
    runs_before = tests_run;
    test_id = id;
    build_message(id);
    // first chunk goes out with the start pulse
    start_i = 1'b1;
    while (sent < msg.size()) begin
      if (gap == 0 && credits > 0) begin
        chunk_valid_i = 1'b1;
        chunk_i = msg[sent];
        eof_i = (sent == msg.size() - 1);
        credits--;
        sent++;
        take_bits(host_lfsr, 2, val);
        gap = int'(val);
      end else begin
        chunk_valid_i = 1'b0;
        eof_i = 1'b0;
        if (gap > 0) begin
          gap--;
        end
      end
      next_cycle();
      start_i = 1'b0;
    end
    chunk_valid_i = 1'b0;
    eof_i = 1'b0;
    while (!done_o) begin
      next_cycle();
    end
    // the checker counts the test on the clock after done rises
    while (tests_run == runs_before) begin
      next_cycle();
    end
  endtask

  // sram model with 0 to 3 wait cycles before ack
  initial begin
    wbs_ack_i = 1'b0;
    wbs_dat_i = '0;
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      mem[i] = {huff_pkg::sym_t'(i), ~huff_pkg::sym_t'(i), 8'h5a, huff_pkg::sym_t'(i)};
    end
    forever begin
      @(posedge hwclk);
      #1;
      if (wbs_ack_i) begin
        wbs_ack_i = 1'b0;
      end else if (wbs_cyc_o && wbs_stb_o) begin
        if (!ack_armed) begin
          take_bits(ack_lfsr, 2, ack_val);
          ack_wait = int'(ack_val);
          ack_armed = 1'b1;
        end
        if (ack_wait == 0) begin
          sram_idx = wbs_adr_o[9:2];
          if (wbs_we_o) begin
            mem[sram_idx] = wbs_dat_o;
          end else begin
            wbs_dat_i = mem[sram_idx];
          end
          wbs_ack_i = 1'b1;
          ack_armed = 1'b0;
        end else begin
          ack_wait--;
        end
      end
    end
  end

  always @(posedge hwclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    start_i = 1'b0;
    chunk_valid_i = 1'b0;
    chunk_i = '0;
    eof_i = 1'b0;
    credits = huff_pkg::CHUNK_CREDITS;
    test_id = 0;
    limit = cycle_limit();
    repeat (5) @(posedge hwclk);
    #1;
    reset = 1'b0;
    repeat (2) next_cycle();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run == NUM_TESTS) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
hdl/huff_pkg.sv
hdl/chunk_packer.sv
hdl/wb_manager.sv
hdl/hist_builder.sv
hdl/least_finder.sv
hdl/huff_controller.sv
hdl/huff_front_top.sv
dv/huff_checker.sv
dv/tb_huff_front.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the huffman front end testbench with verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_huff_front \
  -f filelist.f \
  -o sim_huff_front

./obj_dir/sim_huff_front | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished, see sim.log"
